//--- src/cache_pkg.sv
/*
 * data cache bank definitions
 * geometry, vector types, stream payloads and the miss FSM states
 */
package cache_pkg;

    // geometry
    localparam int WORD_W          = 32;
    localparam int WORD_BYTES      = 4;
    localparam int LINE_WORDS      = 4;
    localparam int NUM_LINES       = 16;
    localparam int TAG_BITS        = 6;
    localparam int REQ_TAG_W       = 4;
    localparam int WORD_SEL_W      = $clog2(LINE_WORDS);
    localparam int LINE_IDX_W      = $clog2(NUM_LINES);
    localparam int LINE_ADDR_W     = TAG_BITS + LINE_IDX_W;

    // queues
    localparam int CRSQ_DEPTH      = 2;
    localparam int MREQ_DEPTH      = 4;
    localparam int PIPELINE_STAGES = 2;
    // leaves room for everything already in flight in the pipeline
    localparam int MREQ_ALM_FULL   = MREQ_DEPTH - PIPELINE_STAGES;

    typedef logic [WORD_W-1:0]                      word_t;
    typedef logic [LINE_WORDS-1:0][WORD_W-1:0]      line_t;
    typedef logic [WORD_SEL_W-1:0]                  word_sel_t;
    typedef logic [WORD_BYTES-1:0]                  word_byteen_t;
    typedef logic [LINE_WORDS-1:0][WORD_BYTES-1:0]  line_byteen_t;
    typedef logic [LINE_IDX_W-1:0]                  line_idx_t;
    typedef logic [TAG_BITS-1:0]                    line_tag_t;
    typedef logic [LINE_ADDR_W-1:0]                 line_addr_t;
    typedef logic [REQ_TAG_W-1:0]                   req_tag_t;

    typedef struct packed {
        logic         rw;
        line_addr_t   addr;
        word_sel_t    wsel;
        word_byteen_t byteen;
        word_t        data;
        req_tag_t     tag;
    } core_req_t;

    typedef struct packed {
        word_t    data;
        req_tag_t tag;
    } core_rsp_t;

    typedef struct packed {
        logic         rw;
        line_addr_t   addr;
        line_byteen_t byteen;
        line_t        data;
    } mem_req_t;

    // record carried through both pipeline stages
    typedef struct packed {
        logic      is_fill;
        logic      is_replay;
        core_req_t req;
        line_t     fill_line;
    } bank_op_t;

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_WAIT_FILL,
        MISS_REPLAY
    } miss_state_t;

endpackage

//--- src/cache_fifo.sv
/*
 * synchronous FIFO
 * circular buffer with occupancy count, head shown on data_out
 */
`timescale 1ns/10ps

module cache_fifo #(
    parameter int DEPTH    = 4,
    parameter int DATA_W   = 8,
    parameter int ALM_FULL = DEPTH - 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  logic              pop,
    input  logic [DATA_W-1:0] data_in,
    output logic [DATA_W-1:0] data_out,
    output logic              empty,
    output logic              full,
    output logic              alm_full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // storage only, the pointers qualify it
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    assign data_out = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign alm_full = (count >= CNT_W'(ALM_FULL));

endmodule

//--- src/cache_tag_store.sv
/*
 * tag store for the direct-mapped bank
 * one valid bit and one tag per line, combinational hit lookup
 */
`timescale 1ns/10ps

module cache_tag_store (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::line_idx_t  lookup_idx,
    input  cache_pkg::line_tag_t  lookup_tag,
    input  logic                  fill,
    output logic                  hit
);
    import cache_pkg::*;

    logic [NUM_LINES-1:0] valid_q;
    line_tag_t            tags_q [NUM_LINES];

    // valid bits start cleared, nothing is cached after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[lookup_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags_q[lookup_idx] <= lookup_tag;
        end
    end

    assign hit = valid_q[lookup_idx] && (tags_q[lookup_idx] == lookup_tag);

endmodule

//--- src/cache_data_store.sv
/*
 * line data array
 * whole-line fill, byte-enabled word write, word read of the indexed line
 */
`timescale 1ns/10ps

module cache_data_store (
    input  logic                     clk,
    input  cache_pkg::line_idx_t     line_idx,
    input  logic                     fill,
    input  cache_pkg::line_t         fill_line,
    input  logic                     write,
    input  cache_pkg::word_sel_t     word_idx,
    input  cache_pkg::word_byteen_t  write_byteen,
    input  cache_pkg::word_t         write_word,
    output cache_pkg::word_t         read_word
);
    import cache_pkg::*;

    line_t lines_q [NUM_LINES];

    always_ff @(posedge clk) begin
        if (fill) begin
            lines_q[line_idx] <= fill_line;
        end else if (write) begin
            // merge only the enabled bytes of the selected word
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (write_byteen[b]) begin
                    lines_q[line_idx][word_idx][b*8 +: 8] <= write_word[b*8 +: 8];
                end
            end
        end
    end

    // old contents until the write edge
    assign read_word = lines_q[line_idx][word_idx];

endmodule

//--- src/cache_miss_unit.sv
/*
 * single-entry miss unit
 * holds one missed read until its fill is in, then replays it
 */
`timescale 1ns/10ps

module cache_miss_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  allocate,
    input  cache_pkg::core_req_t  allocate_req,
    input  logic                  fill_fire,
    output logic                  replay_valid,
    output cache_pkg::core_req_t  replay_req,
    input  logic                  replay_ready,
    output logic                  busy
);
    import cache_pkg::*;

    miss_state_t state_q;
    miss_state_t state_d;
    core_req_t   req_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            MISS_IDLE: begin
                if (allocate) begin
                    state_d = MISS_WAIT_FILL;
                end
            end
            MISS_WAIT_FILL: begin
                // line is written by the fill one cycle ahead of the replay
                if (fill_fire) begin
                    state_d = MISS_REPLAY;
                end
            end
            MISS_REPLAY: begin
                if (replay_ready) begin
                    state_d = MISS_IDLE;
                end
            end
            default: state_d = MISS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= MISS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (allocate && (state_q == MISS_IDLE)) begin
            req_q <= allocate_req;
        end
    end

    assign replay_valid = (state_q == MISS_REPLAY);
    assign replay_req   = req_q;
    assign busy         = (state_q != MISS_IDLE);

endmodule

//--- src/cache_bank.sv
/*
 * direct-mapped write-through data cache bank
 * two-stage pipeline, single outstanding miss, no allocate on write
 * core and memory sides are valid/ready streams
 */
`timescale 1ns/10ps

module cache_bank (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  core_req_valid,
    input  cache_pkg::core_req_t  core_req,
    output logic                  core_req_ready,
    output logic                  core_rsp_valid,
    output cache_pkg::core_rsp_t  core_rsp,
    input  logic                  core_rsp_ready,
    output logic                  mem_req_valid,
    output cache_pkg::mem_req_t   mem_req,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    input  cache_pkg::line_t      mem_rsp_data,
    output logic                  mem_rsp_ready
);
    import cache_pkg::*;

    logic         init_done;
    logic         replay_valid;
    logic         replay_ready;
    core_req_t    replay_req;
    logic         miss_busy;
    logic         allocate;
    logic         replay_fire;
    logic         fill_fire;
    logic         creq_fire;
    logic         sel_valid;
    bank_op_t     sel_op;
    logic         st0_valid;
    logic         st1_valid;
    bank_op_t     st0_op;
    bank_op_t     st1_op;
    line_idx_t    st0_idx;
    line_tag_t    st0_tag;
    logic         hit_st0;
    word_t        rdata_st0;
    logic         st1_hit;
    word_t        st1_rdata;
    logic         read_st0;
    logic         read_st1;
    logic         write_st1;
    logic         stall;
    logic         crsp_push;
    logic         crsp_full;
    logic         crsp_empty;
    core_rsp_t    crsp_in;
    logic         mreq_push;
    logic         mreq_empty;
    logic         mreq_alm_full;
    mem_req_t     mreq_in;
    line_byteen_t wt_byteen;

    // holds core requests off during and right after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            init_done <= 1'b0;
        end else begin
            init_done <= 1'b1;
        end
    end

    assign read_st0  = st0_valid && !st0_op.is_fill && !st0_op.req.rw;
    assign read_st1  = st1_valid && !st1_op.is_fill && !st1_op.req.rw;
    assign write_st1 = st1_valid && !st1_op.is_fill && st1_op.req.rw;

    // only a read hit waiting on a full response queue freezes the pipe
    assign stall = read_st1 && st1_hit && crsp_full;

    // input arbitration: replay, then fill, then core
    assign replay_ready   = !stall;
    assign mem_rsp_ready  = !replay_valid && !mreq_alm_full && !stall;
    assign core_req_ready = init_done && !replay_valid && !mem_rsp_valid && !miss_busy
                         && !read_st0 && !read_st1 && !mreq_alm_full && !stall;

    assign replay_fire = replay_valid && replay_ready;
    assign fill_fire   = mem_rsp_valid && mem_rsp_ready;
    assign creq_fire   = core_req_valid && core_req_ready;
    assign sel_valid   = replay_fire || fill_fire || creq_fire;

    always_comb begin
        sel_op = '0;
        if (replay_valid) begin
            sel_op.is_replay = 1'b1;
            sel_op.req       = replay_req;
        end else if (mem_rsp_valid) begin
            // only one fill is outstanding, its address sits in the miss unit
            sel_op.is_fill   = 1'b1;
            sel_op.req.addr  = replay_req.addr;
            sel_op.fill_line = mem_rsp_data;
        end else begin
            sel_op.req = core_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st0_valid <= 1'b0;
            st1_valid <= 1'b0;
        end else if (!stall) begin
            st0_valid <= sel_valid;
            st1_valid <= st0_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            st0_op    <= sel_op;
            st1_op    <= st0_op;
            st1_hit   <= hit_st0;
            st1_rdata <= rdata_st0;
        end
    end

    // stage 0 lookup and store updates
    assign st0_idx = st0_op.req.addr[LINE_IDX_W-1:0];
    assign st0_tag = st0_op.req.addr[LINE_ADDR_W-1:LINE_IDX_W];

    cache_tag_store tag_store (
        .clk        (clk),
        .rst        (rst),
        .lookup_idx (st0_idx),
        .lookup_tag (st0_tag),
        .fill       (st0_valid && st0_op.is_fill && !stall),
        .hit        (hit_st0)
    );

    cache_data_store data_store (
        .clk          (clk),
        .line_idx     (st0_idx),
        .fill         (st0_valid && st0_op.is_fill && !stall),
        .fill_line    (st0_op.fill_line),
        .write        (st0_valid && !st0_op.is_fill && st0_op.req.rw && hit_st0 && !stall),
        .word_idx     (st0_op.req.wsel),
        .write_byteen (st0_op.req.byteen),
        .write_word   (st0_op.req.data),
        .read_word    (rdata_st0)
    );

    // a replay never misses, so only first-time reads allocate
    assign allocate = read_st1 && !st1_hit && !st1_op.is_replay;

    cache_miss_unit miss_unit (
        .clk          (clk),
        .rst          (rst),
        .allocate     (allocate),
        .allocate_req (st1_op.req),
        .fill_fire    (fill_fire),
        .replay_valid (replay_valid),
        .replay_req   (replay_req),
        .replay_ready (replay_ready),
        .busy         (miss_busy)
    );

    // core responses
    assign crsp_push    = read_st1 && st1_hit && !stall;
    assign crsp_in.data = st1_rdata;
    assign crsp_in.tag  = st1_op.req.tag;

    cache_fifo #(
        .DEPTH    (CRSQ_DEPTH),
        .DATA_W   ($bits(core_rsp_t)),
        .ALM_FULL (CRSQ_DEPTH)
    ) core_rsp_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (crsp_push),
        .pop      (core_rsp_valid && core_rsp_ready),
        .data_in  (crsp_in),
        .data_out (core_rsp),
        .empty    (crsp_empty),
        .full     (crsp_full),
        .alm_full ()
    );

    assign core_rsp_valid = !crsp_empty;

    // write-through enables only the bytes of the selected word
    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            wt_byteen[w] = (word_sel_t'(w) == st1_op.req.wsel) ? st1_op.req.byteen : '0;
        end
    end

    // fill request on a read miss, memory write for every core write
    assign mreq_push      = (read_st1 && !st1_hit) || write_st1;
    assign mreq_in.rw     = st1_op.req.rw;
    assign mreq_in.addr   = st1_op.req.addr;
    assign mreq_in.byteen = st1_op.req.rw ? wt_byteen : '1;
    assign mreq_in.data   = {LINE_WORDS{st1_op.req.data}};

    cache_fifo #(
        .DEPTH    (MREQ_DEPTH),
        .DATA_W   ($bits(mem_req_t)),
        .ALM_FULL (MREQ_ALM_FULL)
    ) mem_req_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (mreq_push),
        .pop      (mem_req_valid && mem_req_ready),
        .data_in  (mreq_in),
        .data_out (mem_req),
        .empty    (mreq_empty),
        .full     (),
        .alm_full (mreq_alm_full)
    );

    assign mem_req_valid = !mreq_empty;

endmodule

//--- dv/cache_bank_assert.sv
/*
 * protocol checks for the data cache bank
 * bound into every cache_bank instance
 */
`timescale 1ns/10ps

module cache_bank_assert (
    input logic                 clk,
    input logic                 rst,
    input logic                 core_req_valid,
    input logic                 core_req_ready,
    input logic                 allocate,
    input logic                 replay_valid,
    input logic                 replay_ready,
    input logic                 core_rsp_valid,
    input logic                 core_rsp_ready,
    input cache_pkg::core_rsp_t core_rsp,
    input logic                 mem_req_valid,
    input logic                 mem_req_ready,
    input cache_pkg::mem_req_t  mem_req,
    input logic                 st1_valid,
    input cache_pkg::bank_op_t  st1_op,
    input logic                 st1_hit
);
    logic miss_open;

    // a miss stays open from its allocate until its replay is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            miss_open <= 1'b0;
        end else if (allocate) begin
            miss_open <= 1'b1;
        end else if (replay_valid && replay_ready) begin
            miss_open <= 1'b0;
        end
    end

    // the fill writes the line before its replay looks it up
    replay_hits: assert property (@(posedge clk) disable iff (rst)
        (st1_valid && st1_op.is_replay) |-> st1_hit)
        else $error("replayed read missed in stage 1");

    core_rsp_held: assert property (@(posedge clk) disable iff (rst)
        (core_rsp_valid && !core_rsp_ready) |=> (core_rsp_valid && $stable(core_rsp)))
        else $error("core response changed while stalled");

    mem_req_held: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)))
        else $error("memory request changed while stalled");

    no_accept_on_miss: assert property (@(posedge clk) disable iff (rst)
        (core_req_valid && core_req_ready) |-> !miss_open)
        else $error("core request accepted while a miss was outstanding");

endmodule

bind cache_bank cache_bank_assert bank_checks (
    .clk            (clk),
    .rst            (rst),
    .core_req_valid (core_req_valid),
    .core_req_ready (core_req_ready),
    .allocate       (allocate),
    .replay_valid   (replay_valid),
    .replay_ready   (replay_ready),
    .core_rsp_valid (core_rsp_valid),
    .core_rsp_ready (core_rsp_ready),
    .core_rsp       (core_rsp),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .st1_valid      (st1_valid),
    .st1_op         (st1_op),
    .st1_hit        (st1_hit)
);

//--- dv/cache_bank_tb.sv
/*
 * testbench for the data cache bank
 * directed and random traffic against an in-order memory model
 */
`timescale 1ns/10ps

module cache_bank_tb;
    import cache_pkg::*;

    localparam int N_RANDOM  = 200;
    localparam int N_OPS     = N_RANDOM + 8;
    localparam int MEM_WORDS = (1 << LINE_ADDR_W) * LINE_WORDS;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    logic       core_req_valid = 1'b0;
    core_req_t  core_req = '0;
    logic       core_req_ready;
    logic       core_rsp_valid;
    core_rsp_t  core_rsp;
    logic       core_rsp_ready = 1'b1;
    logic       mem_req_valid;
    mem_req_t   mem_req;
    logic       mem_req_ready = 1'b1;
    logic       mem_rsp_valid = 1'b0;
    line_t      mem_rsp_data = '0;
    logic       mem_rsp_ready;

    word_t      mem_words [MEM_WORDS];
    word_t      shadow [MEM_WORDS];
    core_rsp_t  exp_rsp_q [$];
    mem_req_t   exp_wt_q [$];
    line_t      fill_q [$];
    int         fill_count = 0;
    line_addr_t last_fill_addr = '0;
    int         fill_delay = 2;
    logic       rsp_taken = 1'b0;
    logic       bp_en = 1'b0;
    int         test_checks = 0;
    int         test_errors = 0;
    int         rsp_checks = 0;
    int         rsp_errors = 0;
    int         wt_checks = 0;
    int         wt_errors = 0;
    string      test_name = "after_reset";
    time        accept_time;
    req_tag_t   next_tag = '0;

    cache_bank dut0 (
        .clk            (clk),
        .rst            (rst),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    always #50 clk = ~clk;

    // every bit of the word address shows up in the pattern
    function automatic word_t init_word(int idx);
        return {idx[11:0], 4'h5, ~idx[11:0], 4'ha};
    endfunction

    function automatic int word_index(line_addr_t addr, int w);
        return int'(addr) * LINE_WORDS + w;
    endfunction

    // memory word as it stands after the request
    function automatic word_t expected_word(word_t old_word, core_req_t req);
        word_t result;
        result = old_word;
        if (req.rw) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (req.byteen[b]) begin
                    result[b*8 +: 8] = req.data[b*8 +: 8];
                end
            end
        end
        return result;
    endfunction

    function automatic mem_req_t expected_write(core_req_t req);
        mem_req_t m;
        m = '0;
        m.rw = 1'b1;
        m.addr = req.addr;
        m.byteen[req.wsel] = req.byteen;
        for (int w = 0; w < LINE_WORDS; w++) begin
            m.data[w] = req.data;
        end
        return m;
    endfunction

    task automatic check_equal(string what, int expected, int actual);
        test_checks++;
        assert (expected == actual) else begin
            test_errors++;
            $display("[FAIL] %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    // entered and left on a falling edge
    task automatic send_req(input logic rw, input line_addr_t addr, input word_sel_t wsel,
                            input word_byteen_t byteen, input word_t data);
        core_req_t req;
        core_rsp_t exp;
        int        idx;
        req.rw = rw;
        req.addr = addr;
        req.wsel = wsel;
        req.byteen = byteen;
        req.data = data;
        req.tag = next_tag;
        next_tag++;
        core_req = req;
        core_req_valid = 1'b1;
        @(posedge clk);
        while (!core_req_ready) begin
            @(posedge clk);
        end
        accept_time = $time;
        idx = word_index(addr, int'(wsel));
        if (rw) begin
            shadow[idx] = expected_word(shadow[idx], req);
            exp_wt_q.push_back(expected_write(req));
        end else begin
            exp.data = expected_word(shadow[idx], req);
            exp.tag = req.tag;
            exp_rsp_q.push_back(exp);
        end
        @(negedge clk);
        core_req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        repeat (4) @(negedge clk);
        while (exp_rsp_q.size() != 0 || exp_wt_q.size() != 0 || fill_q.size() != 0
               || mem_req_valid || mem_rsp_valid) begin
            @(negedge clk);
        end
    endtask

    // memory model serving requests in order
    always @(posedge clk) begin : mem_side
        mem_req_t exp_wt;
        line_t    fill_line;
        rsp_taken = mem_rsp_valid && mem_rsp_ready;
        if (rsp_taken) begin
            void'(fill_q.pop_front());
        end
        if (mem_req_valid && mem_req_ready) begin
            wt_checks++;
            if (mem_req.rw) begin
                assert (exp_wt_q.size() > 0) else begin
                    wt_errors++;
                    $display("memory write arrived with no core write pending");
                end
                if (exp_wt_q.size() > 0) begin
                    exp_wt = exp_wt_q.pop_front();
                    assert (mem_req == exp_wt) else begin
                        wt_errors++;
                        $display("[FAIL] %s: write-through expected %h, actual %h",
                                 test_name, exp_wt, mem_req);
                    end
                end
                for (int w = 0; w < LINE_WORDS; w++) begin
                    for (int b = 0; b < WORD_BYTES; b++) begin
                        if (mem_req.byteen[w][b]) begin
                            mem_words[word_index(mem_req.addr, w)][b*8 +: 8] =
                                mem_req.data[w][b*8 +: 8];
                        end
                    end
                end
            end else begin
                fill_count++;
                last_fill_addr = mem_req.addr;
                // a fill reads the whole line
                assert (mem_req.byteen == '1) else begin
                    wt_errors++;
                    $display("[FAIL] %s: fill byte enables expected %h, actual %h",
                             test_name, line_byteen_t'('1), mem_req.byteen);
                end
                for (int w = 0; w < LINE_WORDS; w++) begin
                    fill_line[w] = mem_words[word_index(mem_req.addr, w)];
                end
                fill_q.push_back(fill_line);
            end
        end
    end

    always @(negedge clk) begin
        if (rsp_taken) begin
            mem_rsp_valid = 1'b0;
            fill_delay = $urandom_range(0, 6);
        end
        if (!mem_rsp_valid && fill_q.size() > 0) begin
            if (fill_delay == 0) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data = fill_q[0];
            end else begin
                fill_delay--;
            end
        end
        core_rsp_ready = bp_en ? 1'($urandom_range(0, 1)) : 1'b1;
        mem_req_ready = bp_en ? ($urandom_range(0, 3) != 0) : 1'b1;
    end

    always @(posedge clk) begin : rsp_check
        core_rsp_t exp;
        if (core_rsp_valid && core_rsp_ready) begin
            rsp_checks++;
            assert (exp_rsp_q.size() > 0) else begin
                rsp_errors++;
                $display("response with tag %0h arrived with no read pending", core_rsp.tag);
            end
            if (exp_rsp_q.size() > 0) begin
                exp = exp_rsp_q.pop_front();
                assert (core_rsp == exp) else begin
                    rsp_errors++;
                    $display("[FAIL] %s: expected tag %0h data %08h, actual tag %0h data %08h",
                             test_name, exp.tag, exp.data, core_rsp.tag, core_rsp.data);
                end
            end
        end
    end

    initial begin : stimulus
        line_addr_t a;
        int         fills0;
        int         errors;
        void'($urandom(71));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = init_word(i);
            shadow[i] = init_word(i);
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        check_equal("core_rsp_valid", 0, int'(core_rsp_valid));
        check_equal("mem_req_valid", 0, int'(mem_req_valid));
        @(negedge clk);
        a = 10'h05a;
        fills0 = fill_count;
        send_req(1'b0, a, 2'd2, 4'h0, '0);
        wait_drain();
        check_equal("fill requests", fills0 + 1, fill_count);
        check_equal("fill address", int'(a), int'(last_fill_addr));

        test_name = "read_hit";
        fills0 = fill_count;
        send_req(1'b0, a, 2'd1, 4'h0, '0);
        @(posedge clk);
        while (!core_rsp_valid) begin
            @(posedge clk);
        end
        check_equal("response latency", 3, int'(($time - accept_time) / 100));
        wait_drain();
        check_equal("fill requests", fills0, fill_count);

        test_name = "write_hit";
        fills0 = fill_count;
        send_req(1'b1, a, 2'd2, 4'($urandom_range(1, 15)), $urandom);
        send_req(1'b0, a, 2'd2, 4'h0, '0);
        wait_drain();
        check_equal("fill requests", fills0, fill_count);

        test_name = "write_miss";
        a = 10'h2c3;
        fills0 = fill_count;
        send_req(1'b1, a, 2'd3, 4'($urandom_range(1, 15)), $urandom);
        wait_drain();
        check_equal("fill requests", fills0, fill_count);
        send_req(1'b0, a, 2'd3, 4'h0, '0);
        wait_drain();
        check_equal("fill requests", fills0 + 1, fill_count);

        test_name = "back_pressure";
        bp_en = 1'b1;
        repeat (N_RANDOM) begin
            send_req(1'($urandom_range(0, 1)), 10'($urandom_range(0, 47)),
                     2'($urandom_range(0, 3)), 4'($urandom_range(1, 15)), $urandom);
        end
        wait_drain();
        bp_en = 1'b0;

        errors = test_errors + rsp_errors + wt_errors;
        $display("checks: %0d tests, %0d responses, %0d memory requests; errors: %0d",
                 test_checks, rsp_checks, wt_checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // about 40 cycles per operation plus reset
    initial begin : watchdog
        #((N_OPS * 40 + 20) * 100);
        $display("timeout: the run did not end within %0d cycles", N_OPS * 40 + 20);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- src.f
src/cache_pkg.sv
src/cache_fifo.sv
src/cache_tag_store.sv
src/cache_data_store.sv
src/cache_miss_unit.sv
src/cache_bank.sv
dv/cache_bank_assert.sv
dv/cache_bank_tb.sv

//--- Makefile
# Verilator build and run for the data cache bank testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= cache_bank_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
